/* verilog.f */
source/memory_pkg.sv
source/turn_sequencer.sv
source/pair_judge.sv
source/score_board.sv
source/card_painter.sv
source/memory_game.sv
tb/clock_gen.sv
tb/memory_game_tb.sv

/* Bender.yml */
package:
  name: memory_game

sources:
  # design, package first
  - files:
      - source/memory_pkg.sv
      - source/turn_sequencer.sv
      - source/pair_judge.sv
      - source/score_board.sv
      - source/card_painter.sv
      - source/memory_game.sv

  # testbench
  - target: test
    files:
      - tb/clock_gen.sv
      - tb/memory_game_tb.sv

/* tb/memory_game_tb.sv */
// memory game testbench: table of whole turns and card sweeps against the game rules
`timescale 1ns/1ps

module memory_game_tb;

	localparam int score_wrap = 9;
	localparam int hold_cycles = 3; // length of each press and release

	typedef struct packed {
		int   first;  // card number, -1 for no card
		int   second;
		logic match;
		logic player; // expected owner of the turn afterwards
		int   s1;
		int   s2;
	} turn_t;

	// partner of each card, pairs 17-10 16-0 15-4 14-3 13-2 12-11 9-7 8-5 6-1
	localparam int pair_tbl [0:17] = '{16, 6, 13, 14, 15, 8, 1, 9, 5, 7, 17, 12, 11, 2, 3, 4, 0, 10};
	// active low digits 0..9, bit 0 is segment a
	localparam logic [6:0] seg_digit [0:9] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
		7'h12, 7'h02, 7'h78, 7'h00, 7'h18};
	localparam int col_x [0:5] = '{7, 33, 59, 85, 111, 137};
	localparam int row_y [0:2] = '{6, 45, 83};

	logic                  clk;
	logic                  reset_n;
	logic                  go;
	logic                  hide;
	memory_pkg::card_sel_t card_sel;
	memory_pkg::x_t        x;
	memory_pkg::y_t        y;
	memory_pkg::colour_t   colour;
	logic                  plot;
	logic                  player;
	memory_pkg::seg_t      seg_p1;
	memory_pkg::seg_t      seg_p2;

	turn_t       turns[$];
	logic [31:0] lfsr = 32'hda89fe37;
	int          checks = 0;
	int          errors = 0;

	clock_gen u_clk (.clk(clk), .reset_n(reset_n));

	memory_game #(.score_wrap(score_wrap)) u_dut (
		.clk(clk), .reset_n(reset_n), .go(go), .hide(hide), .card_sel(card_sel),
		.x(x), .y(y), .colour(colour), .plot(plot), .player(player),
		.seg_p1(seg_p1), .seg_p2(seg_p2)
	);

	task automatic check_val(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual)
		else
		begin
			errors++;
			$display("[FAIL] %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic give_up(input string what);
		errors++;
		$display("timed out while %s", what);
		$display("checks %0d errors %0d", checks, errors);
		$display("TEST FAIL");
		$finish;
	endtask

	// galois lfsr, one step per bit taken
	function automatic int next_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic memory_pkg::card_sel_t onehot(input int c);
		if (c < 0)
			return '0; // all switches down
		return memory_pkg::card_sel_t'(1) << c;
	endfunction

	task automatic add_turn(input int a, input int b, input logic m, input logic p,
		input int s1, input int s2);
		turn_t t;
		t = '{a, b, m, p, s1, s2};
		turns.push_back(t);
	endtask

	// random rows continue from the last fixed row's expectations
	task automatic add_random_turns(input int count);
		turn_t t;
		int    pl;
		int    s[2];
		t = turns[turns.size() - 1];
		pl = t.player;
		s[0] = t.s1;
		s[1] = t.s2;
		for (int i = 0; i < count; i++)
		begin
			t.first = next_bits(5) % 18;
			if (next_bits(1))
				t.second = pair_tbl[t.first]; // force a match now and then
			else
				t.second = next_bits(5) % 18;
			t.match = (pair_tbl[t.first] == t.second);
			if (t.match)
				s[pl] = (s[pl] + 1) % (score_wrap + 1);
			else
				pl = 1 - pl; // miss hands the turn over
			t.player = pl;
			t.s1 = s[0];
			t.s2 = s[1];
			turns.push_back(t);
		end
	endtask

	task automatic build_table();
		add_turn(17, 10, 1, 0, 1, 0);
		add_turn(16, 0, 1, 0, 2, 0);
		add_turn(15, 3, 0, 1, 2, 0);  // miss, player two
		add_turn(14, 3, 1, 1, 2, 1);
		add_turn(-1, 16, 0, 0, 2, 1); // no card on first pick
		add_turn(16, -1, 0, 1, 2, 1); // no card on second pick
		add_turn(1, 6, 1, 1, 2, 2);
		add_turn(5, 8, 1, 1, 2, 3);
		add_turn(2, 2, 0, 0, 2, 3);   // same card twice
		add_turn(13, 2, 1, 0, 3, 3);
		add_turn(12, 11, 1, 0, 4, 3);
		add_turn(9, 7, 1, 0, 5, 3);
		add_turn(7, 9, 1, 0, 6, 3);
		add_turn(4, 15, 1, 0, 7, 3);
		add_turn(3, 14, 1, 0, 8, 3);
		add_turn(0, 16, 1, 0, 9, 3);
		add_turn(10, 17, 1, 0, 0, 3); // tenth match, wraps
		add_turn(6, 1, 1, 0, 1, 3);
		add_random_turns(12);
	endtask

	task automatic pick_card(input int c);
		@(posedge clk);
		card_sel <= onehot(c);
		go <= 1'b1;
		repeat (hold_cycles) @(posedge clk);
		go <= 1'b0; // card taken on this release
		repeat (hold_cycles) @(posedge clk);
	endtask

	task automatic play_turn(input int n, input turn_t t);
		pick_card(t.first);
		pick_card(t.second);
		@(posedge clk);
		go <= 1'b1; // judge press
		repeat (hold_cycles) @(posedge clk);
		go <= 1'b0;
		@(posedge clk); // verdict registered
		@(negedge clk);
		check_val($sformatf("turn %0d match", n), t.match, u_dut.hit);
		@(posedge clk); // score registered
		@(negedge clk);
		check_val($sformatf("turn %0d player", n), t.player, player);
		check_val($sformatf("turn %0d seg_p1", n), seg_digit[t.s1], seg_p1);
		check_val($sformatf("turn %0d seg_p2", n), seg_digit[t.s2], seg_p2);
	endtask

	task automatic wait_plot_low();
		int n;
		n = 0;
		while (plot !== 1'b0 && n < 700)
		begin
			@(negedge clk);
			n++;
		end
		if (plot !== 1'b0)
			give_up("waiting for the painter to go idle");
	endtask

	// every pixel of the sweep against origin plus offset, row-major
	task automatic sweep_check(input string name, input int x0, input int y0,
		input int ca, input int cb);
		int n;
		int t;
		int col;
		int row;
		t = 0;
		@(negedge clk);
		while (plot !== 1'b1 && t < 20)
		begin
			@(negedge clk);
			t++;
		end
		if (plot !== 1'b1)
			give_up({"waiting for plot on ", name});
		n = 0;
		while (plot === 1'b1 && n < 600)
		begin
			col = n % 18;
			row = n / 18;
			check_val($sformatf("%s px %0d x", name, n), x0 + col, x);
			check_val($sformatf("%s px %0d y", name, n), y0 + row, y);
			check_val($sformatf("%s px %0d colour", name, n), (col < 9) ? ca : cb, colour);
			n++;
			@(negedge clk);
		end
		check_val({name, " plot length"}, 504, n);
	endtask

	// origin from the board layout, card 17 top left
	task automatic paint_card(input string name, input int c, input bit by_hide,
		input int ca, input int cb);
		wait_plot_low();
		@(posedge clk);
		card_sel <= onehot(c);
		if (by_hide)
			hide <= 1'b1;
		else
			go <= 1'b1; // press in a pick state reveals
		sweep_check(name, col_x[5 - c % 6], row_y[2 - c / 6], ca, cb);
		@(posedge clk);
		hide <= 1'b0;
		go <= 1'b0;
		repeat (hold_cycles) @(posedge clk);
	endtask

	initial
	begin
		int n;
		go <= 1'b0;
		hide <= 1'b0;
		card_sel <= '0;
		build_table();
		n = 0;
		while (reset_n !== 1'b1 && n < 10)
		begin
			@(posedge clk);
			n++;
		end
		if (reset_n !== 1'b1)
			give_up("waiting for reset release");
		@(negedge clk);
		check_val("reset player", 0, player);
		check_val("reset seg_p1", seg_digit[0], seg_p1);
		check_val("reset seg_p2", seg_digit[0], seg_p2);
		check_val("reset plot", 0, plot);
		for (int i = 0; i < turns.size(); i++)
			play_turn(i, turns[i]);
		paint_card("reveal card 17", 17, 1'b0, 3'b001, 3'b010);
		paint_card("reveal card 8", 8, 1'b0, 3'b101, 3'b111);
		paint_card("hide card 0", 0, 1'b1, 0, 0); // face down is black
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* tb/clock_gen.sv */
// testbench clock and reset source: 100 ns clock, reset low for the first two edges
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic reset_n
);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// synchronous reset, released after two rising edges
	initial
	begin
		reset_n = 1'b0;
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;
	end

endmodule

/* source/memory_game.sv */
// memory game top: connects turn steps, judging, scores and card drawing to the board
`timescale 1ns/1ps

module memory_game #(
	parameter int score_wrap = 9
) (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  go,       // step key
	input  logic                  hide,     // turn card face down
	input  memory_pkg::card_sel_t card_sel, // one-hot switches
	output memory_pkg::x_t        x,
	output memory_pkg::y_t        y,
	output memory_pkg::colour_t   colour,
	output logic                  plot,
	output logic                  player,
	output memory_pkg::seg_t      seg_p1,
	output memory_pkg::seg_t      seg_p2
);

	logic pick_a;
	logic pick_b;
	logic judge;
	logic reveal;
	logic hit;

	turn_sequencer u_turn (
		.clk     (clk),
		.reset_n (reset_n),
		.go      (go),
		.pick_a  (pick_a),
		.pick_b  (pick_b),
		.judge   (judge),
		.reveal  (reveal)
	);

	pair_judge u_judge (
		.clk      (clk),
		.reset_n  (reset_n),
		.card_sel (card_sel),
		.pick_a   (pick_a),
		.pick_b   (pick_b),
		.judge    (judge),
		.hit      (hit),
		.player   (player)
	);

	score_board #(.score_wrap(score_wrap)) u_score (
		.clk     (clk),
		.reset_n (reset_n),
		.hit     (hit),
		.player  (player),
		.seg_p1  (seg_p1),
		.seg_p2  (seg_p2)
	);

	card_painter u_paint (
		.clk      (clk),
		.reset_n  (reset_n),
		.card_sel (card_sel),
		.reveal   (reveal),
		.hide     (hide),
		.x        (x),
		.y        (y),
		.colour   (colour),
		.plot     (plot)
	);

endmodule

/* source/card_painter.sv */
// card painter: sweeps one card rectangle and streams its pixels to the frame buffer
`timescale 1ns/1ps

module card_painter (
	input  logic                  clk,
	input  logic                  reset_n,
	input  memory_pkg::card_sel_t card_sel,
	input  logic                  reveal, // pulse, draw face up
	input  logic                  hide,   // level, rising edge draws face down
	output memory_pkg::x_t        x,
	output memory_pkg::y_t        y,
	output memory_pkg::colour_t   colour,
	output logic                  plot
);

	localparam int col_last = memory_pkg::card_w - 1; // 17
	localparam int row_last = memory_pkg::card_h - 1; // 27

	logic hide_q;
	logic hide_rise;
	logic start;
	logic sel_any;

	memory_pkg::card_idx_t card_q; // card being drawn
	logic                  hidden_q;
	logic                  active_q;
	logic [4:0]            col_q;  // 0..17
	logic [4:0]            row_q;  // 0..27
	logic                  last_px;

	assign hide_rise = hide && !hide_q;
	assign start     = reveal || hide_rise;
	assign sel_any   = |card_sel;
	assign last_px   = (col_q == 5'(col_last)) && (row_q == 5'(row_last));

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			hide_q <= 1'b0;
		else
			hide_q <= hide;
	end

	// latch card on start, restart from the corner
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			card_q   <= '0;
			hidden_q <= 1'b0;
			active_q <= 1'b0;
			col_q    <= '0;
			row_q    <= '0;
		end
		else if (start)
		begin
			card_q   <= memory_pkg::sel_to_idx(card_sel);
			hidden_q <= !reveal; // reveal wins a tie
			active_q <= sel_any; // no card, no sweep
			col_q    <= '0;
			row_q    <= '0;
		end
		else if (active_q)
		begin
			if (last_px)
			begin
				active_q <= 1'b0; // 504th pixel out
				col_q    <= '0;
				row_q    <= '0;
			end
			else if (col_q == 5'(col_last))
			begin
				col_q <= '0; // next row
				row_q <= row_q + 5'd1;
			end
			else
				col_q <= col_q + 5'd1;
		end
	end

	// origin plus offset, row-major
	assign x = memory_pkg::card_x[card_q] + memory_pkg::x_t'(col_q);
	assign y = memory_pkg::card_y[card_q] + memory_pkg::y_t'(row_q);

	// two halves face up, black face down
	always_comb
	begin
		if (hidden_q)
			colour = '0;
		else if (col_q < 5'(memory_pkg::half_w))
			colour = memory_pkg::card_colour_a[card_q]; // left half
		else
			colour = memory_pkg::card_colour_b[card_q];
	end

	assign plot = active_q; // one pixel per cycle while sweeping

endmodule

/* source/score_board.sv */
// score board: two wrapping decimal score digits with seven-segment decode
`timescale 1ns/1ps

module score_board #(
	parameter int score_wrap = 9 // last digit before rolling to 0
) (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             hit,
	input  logic             player,
	output memory_pkg::seg_t seg_p1,
	output memory_pkg::seg_t seg_p2
);

	memory_pkg::digit_t score_q [2]; // index is player

	function automatic memory_pkg::digit_t bump(input memory_pkg::digit_t d);
		if (d == memory_pkg::digit_t'(score_wrap))
			return '0; // wrap
		return d + 4'd1;
	endfunction

	// active low, bit 0 is segment a
	function automatic memory_pkg::seg_t seg_of(input memory_pkg::digit_t d);
		case (d)
			4'd0:    return 7'b1000000;
			4'd1:    return 7'b1111001;
			4'd2:    return 7'b0100100;
			4'd3:    return 7'b0110000;
			4'd4:    return 7'b0011001;
			4'd5:    return 7'b0010010;
			4'd6:    return 7'b0000010;
			4'd7:    return 7'b1111000;
			4'd8:    return 7'b0000000;
			4'd9:    return 7'b0011000;
			default: return 7'b1111111; // blank above 9
		endcase
	endfunction

	// one point for whoever holds the turn
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			score_q[0] <= '0;
			score_q[1] <= '0;
		end
		else if (hit)
			score_q[player] <= bump(score_q[player]);
	end

	assign seg_p1 = seg_of(score_q[0]);
	assign seg_p2 = seg_of(score_q[1]);

endmodule

/* source/pair_judge.sv */
// pair judge: records both picks, checks the pair and keeps the turn owner
`timescale 1ns/1ps

module pair_judge (
	input  logic                 clk,
	input  logic                 reset_n,
	input  memory_pkg::card_sel_t card_sel,
	input  logic                 pick_a,
	input  logic                 pick_b,
	input  logic                 judge,
	output logic                 hit,    // one cycle on match
	output logic                 player  // 0 player one, 1 player two
);

	memory_pkg::card_idx_t sel_idx;
	logic                  sel_any;

	memory_pkg::card_idx_t first_idx;
	memory_pkg::card_idx_t second_idx;
	logic                  first_valid;
	logic                  second_valid;
	logic                  is_pair;

	// lowest set switch is the card
	assign sel_idx = memory_pkg::sel_to_idx(card_sel);
	assign sel_any = |card_sel; // no switch means no card

	// card numbers, only meaningful with their valid flag
	always_ff @(posedge clk)
	begin
		if (pick_a)
			first_idx <= sel_idx;
		if (pick_b)
			second_idx <= sel_idx;
	end

	// valid flags, cleared once the pair is judged
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			first_valid  <= 1'b0;
			second_valid <= 1'b0;
		end
		else if (judge)
		begin
			first_valid  <= 1'b0;
			second_valid <= 1'b0;
		end
		else
		begin
			if (pick_a)
				first_valid <= sel_any;
			if (pick_b)
				second_valid <= sel_any;
		end
	end

	// partner lookup on the first card
	assign is_pair = first_valid && second_valid &&
		(memory_pkg::pair_of[first_idx] == second_idx);

	// verdict; a miss hands the turn over
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			hit    <= 1'b0;
			player <= 1'b0;
		end
		else
		begin
			hit <= 1'b0; // pulse by default
			if (judge)
			begin
				if (is_pair)
					hit <= 1'b1; // same player goes again
				else
					player <= ~player;
			end
		end
	end

endmodule

/* source/turn_sequencer.sv */
// turn sequencer: steps one turn through pick, pick and judge on go presses
`timescale 1ns/1ps

module turn_sequencer (
	input  logic clk,
	input  logic reset_n,
	input  logic go,     // level, high while pressed
	output logic pick_a, // first card taken
	output logic pick_b, // second card taken
	output logic judge,  // pair verdict request
	output logic reveal  // draw the card under the switches
);

	typedef enum logic [2:0] {
		st_pick1,
		st_pick1_wait,
		st_pick2,
		st_pick2_wait,
		st_check,
		st_check_wait
	} state_t;

	state_t state_q;
	state_t state_d;

	// press enters wait, release moves to next step
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			st_pick1:      if (go) state_d = st_pick1_wait;
			st_pick1_wait: if (!go) state_d = st_pick2;
			st_pick2:      if (go) state_d = st_pick2_wait;
			st_pick2_wait: if (!go) state_d = st_check;
			st_check:      if (go) state_d = st_check_wait;
			st_check_wait: if (!go) state_d = st_pick1;
			default:       state_d = st_pick1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			state_q <= st_pick1;
		else
			state_q <= state_d;
	end

	// pulses high for the cycle ending on the moving edge
	// state leaves on that edge, so each lasts one cycle
	assign pick_a = (state_q == st_pick1_wait) && !go; // release of first pick
	assign pick_b = (state_q == st_pick2_wait) && !go;
	assign judge  = (state_q == st_check_wait) && !go;

	// press in either pick state shows the card
	assign reveal = ((state_q == st_pick1) || (state_q == st_pick2)) && go;

endmodule

/* source/memory_pkg.sv */
// memory game package: board geometry, colour width, card and pair tables
package memory_pkg;

	localparam int num_cards = 18; // 3 rows of 6

	typedef logic [num_cards-1:0] card_sel_t; // one-hot switch word
	typedef logic [4:0] card_idx_t;           // card number 0..17
	typedef logic [2:0] colour_t;             // 1 bit per channel
	typedef logic [7:0] x_t;                  // 0..159
	typedef logic [6:0] y_t;                  // 0..119
	typedef logic [3:0] digit_t;              // decimal score digit
	typedef logic [6:0] seg_t;                // active low, g..a

	localparam int card_w = 18;
	localparam int card_h = 28;
	localparam int half_w = 9; // left colour half

	// card origins, index is card number
	// card 17 top left, card 0 bottom right
	localparam x_t card_x [0:num_cards-1] = '{
		8'd137, 8'd111, 8'd85, 8'd59, 8'd33, 8'd7,  // bottom row
		8'd137, 8'd111, 8'd85, 8'd59, 8'd33, 8'd7,  // middle row
		8'd137, 8'd111, 8'd85, 8'd59, 8'd33, 8'd7   // top row
	};
	localparam y_t card_y [0:num_cards-1] = '{
		7'd83, 7'd83, 7'd83, 7'd83, 7'd83, 7'd83,
		7'd45, 7'd45, 7'd45, 7'd45, 7'd45, 7'd45,
		7'd6, 7'd6, 7'd6, 7'd6, 7'd6, 7'd6
	};

	// half colours, pairs share both halves
	localparam colour_t card_colour_a [0:num_cards-1] = '{
		3'b011, 3'b100, 3'b111, 3'b010, 3'b010, 3'b101,  // 0..5
		3'b100, 3'b100, 3'b101, 3'b100, 3'b001, 3'b101,  // 6..11
		3'b101, 3'b111, 3'b010, 3'b010, 3'b011, 3'b001   // 12..17
	};
	localparam colour_t card_colour_b [0:num_cards-1] = '{
		3'b100, 3'b001, 3'b100, 3'b111, 3'b011, 3'b111,
		3'b001, 3'b101, 3'b111, 3'b101, 3'b010, 3'b001,
		3'b001, 3'b100, 3'b111, 3'b011, 3'b100, 3'b010
	};

	// matching partner of each card, symmetric
	localparam card_idx_t pair_of [0:num_cards-1] = '{
		5'd16, 5'd6, 5'd13, 5'd14, 5'd15, 5'd8,   // 0..5
		5'd1, 5'd9, 5'd5, 5'd7, 5'd17, 5'd12,     // 6..11
		5'd11, 5'd2, 5'd3, 5'd4, 5'd0, 5'd10      // 12..17
	};

	// lowest set bit wins, all zero gives 0 (caller checks |sel)
	function automatic card_idx_t sel_to_idx(input card_sel_t sel);
		card_idx_t idx;
		idx = '0;
		for (int i = num_cards - 1; i >= 0; i--)
		begin
			if (sel[i])
				idx = card_idx_t'(i); // later (lower) hits overwrite
		end
		return idx;
	endfunction

endpackage
